//--- filelist.f
+incdir+.
sdram_pkg.sv
slot_arbiter.sv
sdram_sequencer.sv
read_return.sv
sdram_ctrl_top.sv
sdram_chip_model.sv
tb_sdram.sv

//--- read_return.sv
// read data and ack return for one slot
// steers sd_din to the owning client on a capture pulse
`timescale 1ns/100ps

module read_return (
	input  logic                    clk,
	input  logic                    init_n,
	input  sdram_pkg::slot_access_t acc,
	input  logic                    cap,       // sd_din holds this slot's read word
	input  logic                    wdone,     // write just went out
	input  sdram_pkg::word_t        sd_din,
	input  logic                    port_req,  // accepted port toggle
	input  logic                    tog_req,   // accepted toggle reader toggle
	output sdram_pkg::word_t        port_q,
	output logic                    port_ack,
	output sdram_pkg::word_t        watch_q_0,
	output sdram_pkg::word_t        watch_q_1,
	output sdram_pkg::word_t        tog_q,
	output logic                    tog_ack
);

	// acks
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			port_ack <= 1'b0;
			tog_ack  <= 1'b0;
		end else begin
			if (wdone && acc.owner == sdram_pkg::REQ)
				port_ack <= port_req;   // write done
			if (cap) begin
				case (acc.owner)
					sdram_pkg::REQ:    port_ack <= port_req;
					sdram_pkg::TOGGLE: tog_ack  <= tog_req;
					default: ;   // watched readers have no ack
				endcase
			end
		end
	end

	// data registers, same edge as the ack
	always_ff @(posedge clk) begin
		if (cap) begin
			case (acc.owner)
				sdram_pkg::REQ:    port_q    <= sd_din;
				sdram_pkg::WATCH0: watch_q_0 <= sd_din;
				sdram_pkg::WATCH1: watch_q_1 <= sd_din;
				sdram_pkg::TOGGLE: tog_q     <= sd_din;
				default: ;
			endcase
		end
	end

endmodule

//--- run_sim.sh
#!/bin/bash
# build and run the sdram controller testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_sdram -f filelist.f
./obj_dir/Vtb_sdram 2>&1 | tee sim.log
if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- sdram_chip_model.sv
// behavioural sdram for the testbench, cl2, dqm, row tracking per bank
// resolves the split dq bus and reports refreshes, init progress and protocol errors
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_chip_model (
	input  logic                   clk,
	input  sdram_pkg::sdram_pins_t pins,
	input  sdram_pkg::word_t       dq_out,
	input  logic                   dq_oe,
	output sdram_pkg::word_t       dq_in,
	output int                     ref_count,   // auto refreshes seen
	output int                     init_step,   // 4 = full init order seen
	output logic                   proto_err
);

	sdram_pkg::word_t mem [logic [23:0]];   // key {ba, row, col}
	logic [12:0]      open_row [4];
	logic [3:0]       is_open;
	logic             rd_pend;    // READ seen last edge
	logic [23:0]      rd_key;
	logic [1:0]       rd_dqm;
	logic             rd_drive;   // model owns the bus
	sdram_pkg::word_t rd_word;

	// unwritten words, pattern over the whole key
	function automatic sdram_pkg::word_t fill(input logic [23:0] k);
		return k[15:0] ^ {k[23:16], k[23:16]} ^ 16'h5a3c;
	endfunction

	function automatic sdram_pkg::word_t peek(input logic [23:0] k);
		return mem.exists(k) ? mem[k] : fill(k);
	endfunction

	initial begin
		ref_count = 0;
		init_step = 0;
		proto_err = 1'b0;
		is_open   = '0;
		rd_pend   = 1'b0;
		rd_drive  = 1'b0;
		rd_word   = '0;
	end

	// bus resolution
	assign dq_in = dq_oe ? dq_out : (rd_drive ? rd_word : 16'h0000);

	// ------------------------------------------------------------
	always @(posedge clk) begin
		logic [23:0]      k;
		sdram_pkg::word_t w;
		rd_drive <= rd_pend;   // cl2, data out after second edge
		rd_pend  <= 1'b0;
		if (rd_pend)
			rd_word <= peek(rd_key) & {{8{!rd_dqm[1]}}, {8{!rd_dqm[0]}}};
		if (dq_oe && rd_drive)
			proto_err <= 1'b1;   // bus fight
		k = {pins.ba, open_row[pins.ba], pins.a[8:0]};
		case (pins.cmd)
			sdram_pkg::ACTIVE: begin
				if (is_open[pins.ba])
					proto_err <= 1'b1;
				is_open[pins.ba]  <= 1'b1;
				open_row[pins.ba] <= pins.a;
			end
			sdram_pkg::READ, sdram_pkg::WRITE: begin
				if (!is_open[pins.ba])
					proto_err <= 1'b1;
				if (pins.cmd == sdram_pkg::READ) begin
					rd_pend <= 1'b1;
					rd_key  <= k;
					rd_dqm  <= pins.dqm;
				end else begin
					w = peek(k);
					if (!pins.dqm[0]) w[7:0] = dq_out[7:0];
					if (!pins.dqm[1]) w[15:8] = dq_out[15:8];
					mem[k] = w;
				end
				if (pins.a[10])
					is_open[pins.ba] <= 1'b0;   // auto precharge
			end
			sdram_pkg::PRECHARGE: begin
				if (pins.a[10]) is_open <= '0;
				else is_open[pins.ba] <= 1'b0;
				if (init_step == 0 && pins.a[10]) init_step <= 1;
			end
			sdram_pkg::AUTO_REFRESH: begin
				if (|is_open)
					proto_err <= 1'b1;
				ref_count <= ref_count + 1;
				if (init_step == 1 || init_step == 2) init_step <= init_step + 1;
			end
			sdram_pkg::LOAD_MODE:
				if (init_step == 3 && pins.a == `SDRAM_MODE_WORD) init_step <= 4;
			default: ;
		endcase
	end

endmodule

//--- sdram_ctrl_top.sv
// two-slot sdram controller top, slot 0 on banks 0/1 and slot 1 on banks 2/3
// the dq bus stays split in dq_out / dq_oe / dq_in
`timescale 1ns/100ps

module sdram_ctrl_top (
	input  logic                   clk,
	input  logic                   init_n,
	// slot 0 clients
	input  sdram_pkg::req_port_t   port_in_0,
	output logic                   port_ack_0,
	output sdram_pkg::word_t       port_q_0,
	input  sdram_pkg::raddr_t      watch_addr_0_0,
	input  sdram_pkg::raddr_t      watch_addr_0_1,
	output sdram_pkg::word_t       watch_q_0_0,
	output sdram_pkg::word_t       watch_q_0_1,
	input  logic                   tog_req_0,
	input  sdram_pkg::raddr_t      tog_addr_0,
	output logic                   tog_ack_0,
	output sdram_pkg::word_t       tog_q_0,
	// slot 1 clients
	input  sdram_pkg::req_port_t   port_in_1,
	output logic                   port_ack_1,
	output sdram_pkg::word_t       port_q_1,
	input  sdram_pkg::raddr_t      watch_addr_1_0,
	input  sdram_pkg::raddr_t      watch_addr_1_1,
	output sdram_pkg::word_t       watch_q_1_0,
	output sdram_pkg::word_t       watch_q_1_1,
	input  logic                   tog_req_1,
	input  sdram_pkg::raddr_t      tog_addr_1,
	output logic                   tog_ack_1,
	output sdram_pkg::word_t       tog_q_1,
	// chip side
	output sdram_pkg::sdram_pins_t pins,
	output sdram_pkg::word_t       dq_out,
	output logic                   dq_oe,
	input  sdram_pkg::word_t       dq_in,
	output logic                   ready
);

	sdram_pkg::slot_access_t next0, next1, acc0, acc1;
	sdram_pkg::word_t        sd_din;
	logic take0, take1, hold_off0, cap0, cap1, wdone0, wdone1;
	logic port_seen_0, port_seen_1, tog_seen_0, tog_seen_1;

	slot_arbiter u_arb0 (
		.clk, .init_n, .port_in(port_in_0), .port_ack(port_ack_0),
		.watch_addr_0(watch_addr_0_0), .watch_addr_1(watch_addr_0_1),
		.tog_req(tog_req_0), .tog_ack(tog_ack_0), .tog_addr(tog_addr_0),
		.take(take0), .hold_off(hold_off0), .next(next0),
		.port_seen(port_seen_0), .tog_seen(tog_seen_0)
	);

	slot_arbiter u_arb1 (
		.clk, .init_n, .port_in(port_in_1), .port_ack(port_ack_1),
		.watch_addr_0(watch_addr_1_0), .watch_addr_1(watch_addr_1_1),
		.tog_req(tog_req_1), .tog_ack(tog_ack_1), .tog_addr(tog_addr_1),
		.take(take1), .hold_off(1'b0), .next(next1),   // refresh rides on slot 1 idle
		.port_seen(port_seen_1), .tog_seen(tog_seen_1)
	);

	sdram_sequencer u_seq (
		.clk, .init_n, .next0, .next1, .dq_in, .take0, .take1, .hold_off0,
		.pins, .dq_out, .dq_oe, .acc0, .acc1, .cap0, .cap1, .wdone0, .wdone1,
		.sd_din, .ready
	);

	read_return u_ret0 (
		.clk, .init_n, .acc(acc0), .cap(cap0), .wdone(wdone0), .sd_din,
		.port_req(port_seen_0), .tog_req(tog_seen_0),
		.port_q(port_q_0), .port_ack(port_ack_0),
		.watch_q_0(watch_q_0_0), .watch_q_1(watch_q_0_1),
		.tog_q(tog_q_0), .tog_ack(tog_ack_0)
	);

	read_return u_ret1 (
		.clk, .init_n, .acc(acc1), .cap(cap1), .wdone(wdone1), .sd_din,
		.port_req(port_seen_1), .tog_req(tog_seen_1),
		.port_q(port_q_1), .port_ack(port_ack_1),
		.watch_q_0(watch_q_1_0), .watch_q_1(watch_q_1_1),
		.tog_q(tog_q_1), .tog_ack(tog_ack_1)
	);

endmodule

//--- sdram_params.svh
// timing and geometry macros for the two-slot sdram controller
// include in any module that needs a timing value
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

`define SDRAM_MHZ 80                                  // sdram clock, sets refresh spacing
`define SDRAM_REFRESH_CYCLES (78 * `SDRAM_MHZ / 10)   // 64 ms / 8192 rows = 7.8 us
`define SDRAM_INIT_ROUNDS 32                          // rounds of wait plus init
`define SDRAM_ROUND_LEN 7                             // cycles per interleaved round

// reserved, single writes, std op, cl2, sequential, burst 1
`define SDRAM_MODE_WORD 13'b000_1_00_010_0_000

// command phases inside the round
`define SDRAM_PH_RAS0 3'd0
`define SDRAM_PH_CAS0 3'd3
`define SDRAM_PH_RAS1 3'd4
`define SDRAM_PH_CAS1 3'd6
// read data sits in sd_din here
`define SDRAM_PH_RET0 3'd0
`define SDRAM_PH_RET1 3'd3

`endif

//--- sdram_pkg.sv
// shared types of the sdram controller
// referenced by scoped name from every design file
package sdram_pkg;

	typedef logic [15:0] word_t;   // data word
	typedef logic [22:0] waddr_t;  // word address a[23:1] inside a slot
	typedef logic [15:0] raddr_t;  // watched / toggle reader address
	typedef logic [1:0]  mask_t;   // byte select, 1 = byte used
	typedef logic [2:0]  phase_t;  // position in the round

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		INHIBIT      = 4'b1111,
		NOP          = 4'b0111,
		ACTIVE       = 4'b0011,
		READ         = 4'b0101,
		WRITE        = 4'b0100,
		PRECHARGE    = 4'b0010,
		AUTO_REFRESH = 4'b0001,
		LOAD_MODE    = 4'b0000
	} sdram_cmd_t;

	typedef enum logic [2:0] {NONE, REQ, WATCH0, WATCH1, TOGGLE} client_t;
	typedef enum logic [1:0] {WAIT, INIT, RUN} seq_mode_t;

	typedef struct packed {
		logic   req;   // toggles for a new request
		logic   we;
		waddr_t a;
		mask_t  ds;
		word_t  d;
	} req_port_t;

	typedef struct packed {
		client_t owner;
		waddr_t  a;
		logic    we;
		logic    oe;   // read
		mask_t   ds;
		word_t   d;
	} slot_access_t;

	typedef struct packed {
		sdram_cmd_t  cmd;
		logic [12:0] a;
		logic [1:0]  ba;
		logic [1:0]  dqm;
	} sdram_pins_t;

endpackage

//--- sdram_sequencer.sv
// round counter, init sequence, refresh and command issue for both slots
// drives the chip pins, hands the latched accesses to the return units
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_sequencer (
	input  logic                    clk,
	input  logic                    init_n,
	input  sdram_pkg::slot_access_t next0,
	input  sdram_pkg::slot_access_t next1,
	input  sdram_pkg::word_t        dq_in,
	output logic                    take0,
	output logic                    take1,
	output logic                    hold_off0,   // blocks slot 0 after a refresh
	output sdram_pkg::sdram_pins_t  pins,
	output sdram_pkg::word_t        dq_out,
	output logic                    dq_oe,
	output sdram_pkg::slot_access_t acc0,
	output sdram_pkg::slot_access_t acc1,
	output logic                    cap0,
	output logic                    cap1,
	output logic                    wdone0,
	output logic                    wdone1,
	output sdram_pkg::word_t        sd_din,
	output logic                    ready
);

	// init countdown values where commands go out
	localparam logic [5:0] CNT_PRE   = 6'd15;
	localparam logic [5:0] CNT_REF_A = 6'd10;
	localparam logic [5:0] CNT_REF_B = 6'd8;
	localparam logic [5:0] CNT_LMR   = 6'd2;
	localparam sdram_pkg::phase_t PH_LAST = sdram_pkg::phase_t'(`SDRAM_ROUND_LEN - 1);

	sdram_pkg::phase_t    phase;
	sdram_pkg::seq_mode_t mode;
	logic [5:0]           init_cnt;   // rounds left
	logic [10:0]          rcnt;       // cycles since last refresh
	logic                 refresh;
	logic                 need_refresh;

	// ACTIVE for a slot, bank = slot bit and a[23]
	function automatic sdram_pkg::sdram_pins_t act_pins(input logic slot,
			input sdram_pkg::slot_access_t acc);
		sdram_pkg::sdram_pins_t p;
		p.cmd = sdram_pkg::ACTIVE;
		p.a   = acc.a[21:9];            // row a[22:10]
		p.ba  = {slot, acc.a[22]};
		p.dqm = 2'b11;
		return p;
	endfunction

	// READ / WRITE with auto precharge
	function automatic sdram_pkg::sdram_pins_t cas_pins(input logic slot,
			input sdram_pkg::slot_access_t acc);
		sdram_pkg::sdram_pins_t p;
		p.cmd = acc.we ? sdram_pkg::WRITE : sdram_pkg::READ;
		p.a   = {4'b0010, acc.a[8:0]};  // a10 set, column a[9:1]
		p.ba  = {slot, acc.a[22]};
		p.dqm = ~acc.ds;
		return p;
	endfunction

	assign ready        = mode == sdram_pkg::RUN;
	assign take0        = ready && (phase == `SDRAM_PH_RAS0);
	assign take1        = ready && (phase == `SDRAM_PH_RAS1);
	assign hold_off0    = refresh;
	assign need_refresh = rcnt >= 11'(`SDRAM_REFRESH_CYCLES);
	assign cap0         = (phase == `SDRAM_PH_RET0) && acc0.oe;   // acc only set in RUN
	assign cap1         = (phase == `SDRAM_PH_RET1) && acc1.oe;

	// ------------------------------------------------------------
	// round counter and init countdown
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			phase    <= '0;
			init_cnt <= 6'(`SDRAM_INIT_ROUNDS - 1);
			mode     <= sdram_pkg::WAIT;
		end else begin
			phase <= (phase == PH_LAST) ? '0 : phase + 3'd1;
			if (phase == PH_LAST && init_cnt != '0) begin
				init_cnt <= init_cnt - 6'd1;
				if (init_cnt == 6'd1)
					mode <= sdram_pkg::RUN;
				else if (init_cnt == CNT_PRE + 6'd1)
					mode <= sdram_pkg::INIT;   // precharge round is next
			end
		end
	end

	// ------------------------------------------------------------
	// command issue
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			pins    <= '{cmd: sdram_pkg::NOP, a: '0, ba: '0, dqm: 2'b11};
			dq_oe   <= 1'b0;
			acc0    <= '0;
			acc1    <= '0;
			refresh <= 1'b0;
			rcnt    <= '0;
			wdone0  <= 1'b0;
			wdone1  <= 1'b0;
		end else begin
			pins.cmd <= sdram_pkg::NOP;   // idle by default
			pins.dqm <= 2'b11;
			dq_oe    <= 1'b0;
			wdone0   <= 1'b0;
			wdone1   <= 1'b0;
			if (ready && rcnt != '1)
				rcnt <= rcnt + 11'd1;   // saturates

			if (mode == sdram_pkg::INIT && phase == `SDRAM_PH_RAS0) begin
				case (init_cnt)
					CNT_PRE: begin
						pins.cmd   <= sdram_pkg::PRECHARGE;
						pins.a[10] <= 1'b1;   // all banks
					end
					CNT_REF_A, CNT_REF_B: pins.cmd <= sdram_pkg::AUTO_REFRESH;
					CNT_LMR: begin
						pins.cmd <= sdram_pkg::LOAD_MODE;
						pins.a   <= `SDRAM_MODE_WORD;
						pins.ba  <= 2'b00;
					end
					default: ;
				endcase
			end

			// slot 0, banks 0 and 1
			if (take0) begin
				acc0 <= next0;
				if (next0.owner != sdram_pkg::NONE)
					pins <= act_pins(1'b0, next0);
			end
			if (phase == `SDRAM_PH_CAS0 && (acc0.we || acc0.oe)) begin
				pins   <= cas_pins(1'b0, acc0);
				dq_oe  <= acc0.we;
				wdone0 <= acc0.we;   // high while WRITE is on the pins
			end

			// slot 1, banks 2 and 3, refresh takes its idle ras slot
			if (take1) begin
				acc1    <= next1;
				refresh <= 1'b0;
				if (next1.owner != sdram_pkg::NONE) begin
					pins <= act_pins(1'b1, next1);
				end else if (need_refresh && !(acc0.we || acc0.oe)) begin
					pins.cmd <= sdram_pkg::AUTO_REFRESH;
					refresh  <= 1'b1;
					rcnt     <= '0;
				end
			end
			if (phase == `SDRAM_PH_CAS1 && (acc1.we || acc1.oe)) begin
				pins   <= cas_pins(1'b1, acc1);
				dq_oe  <= acc1.we;
				wdone1 <= acc1.we;
			end
		end
	end

	// data path
	always_ff @(posedge clk) begin
		sd_din <= dq_in;   // sampled every cycle
		if (phase == `SDRAM_PH_CAS0 && acc0.we)
			dq_out <= acc0.d;
		else if (phase == `SDRAM_PH_CAS1 && acc1.we)
			dq_out <= acc1.d;
	end

endmodule

//--- slot_arbiter.sv
// client selection for one slot of the controller
// presents the next access, updates its request state when the sequencer takes it
`timescale 1ns/100ps

module slot_arbiter (
	input  logic                    clk,
	input  logic                    init_n,
	input  sdram_pkg::req_port_t    port_in,
	input  logic                    port_ack,
	input  sdram_pkg::raddr_t       watch_addr_0,
	input  sdram_pkg::raddr_t       watch_addr_1,
	input  logic                    tog_req,
	input  logic                    tog_ack,
	input  sdram_pkg::raddr_t       tog_addr,
	input  logic                    take,       // ras phase of this slot
	input  logic                    hold_off,   // refresh under way
	output sdram_pkg::slot_access_t next,
	output logic                    port_seen,  // last accepted port req
	output logic                    tog_seen    // last accepted toggle req
);

	sdram_pkg::raddr_t last_0;   // address of last watch 0 read
	sdram_pkg::raddr_t last_1;
	logic              port_pend;
	logic              tog_pend;
	logic              w0_chg;
	logic              w1_chg;

	// reader address into its region, upper bits zero
	function automatic sdram_pkg::waddr_t region_addr(input logic [1:0] region,
			input sdram_pkg::raddr_t ra);
		return {5'd0, region, ra};
	endfunction

	// new toggle only once the previous one is acked
	assign port_pend = (port_in.req != port_seen) && (port_ack == port_seen);
	assign tog_pend  = (tog_req != tog_seen) && (tog_ack == tog_seen);
	assign w0_chg    = watch_addr_0 != last_0;
	assign w1_chg    = watch_addr_1 != last_1;

	// ------------------------------------------------------------
	// priority: port, watch 0, watch 1, toggle
	always_comb begin
		next = '0;   // owner NONE, no access
		if (hold_off) begin
			next.owner = sdram_pkg::NONE;
		end else if (port_pend) begin
			next.owner = sdram_pkg::REQ;
			next.a     = port_in.a;
			next.we    = port_in.we;
			next.oe    = !port_in.we;
			next.ds    = port_in.ds;
			next.d     = port_in.d;
		end else if (w0_chg) begin
			next.owner = sdram_pkg::WATCH0;
			next.a     = region_addr(2'b00, watch_addr_0);
			next.oe    = 1'b1;
			next.ds    = 2'b11;   // full word
		end else if (w1_chg) begin
			next.owner = sdram_pkg::WATCH1;
			next.a     = region_addr(2'b10, watch_addr_1);
			next.oe    = 1'b1;
			next.ds    = 2'b11;
		end else if (tog_pend) begin
			next.owner = sdram_pkg::TOGGLE;
			next.a     = region_addr(2'b01, tog_addr);
			next.oe    = 1'b1;
			next.ds    = 2'b11;
		end
	end

	// ------------------------------------------------------------
	// record the grant
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			last_0    <= '0;   // address 0 counts as already read
			last_1    <= '0;
			port_seen <= 1'b0;
			tog_seen  <= 1'b0;
		end else if (take) begin
			case (next.owner)
				sdram_pkg::REQ:    port_seen <= port_in.req;
				sdram_pkg::WATCH0: last_0    <= watch_addr_0;
				sdram_pkg::WATCH1: last_1    <= watch_addr_1;
				sdram_pkg::TOGGLE: tog_seen  <= tog_req;
				default: ;
			endcase
		end
	end

endmodule

//--- tb_sdram.sv
// directed tests for the two-slot sdram controller against a chip model
// built and run by run_sim.sh along with the design and the chip model
`timescale 1ns/100ps
`include "sdram_params.svh"

module tb_sdram;

	localparam int RLEN = `SDRAM_ROUND_LEN;
	localparam int GAP_MAX = `SDRAM_REFRESH_CYCLES + 14;

	logic clk = 1'b0;
	logic init_n;
	sdram_pkg::req_port_t   port_in [2];
	logic                   port_ack [2];
	sdram_pkg::word_t       port_q [2];
	sdram_pkg::raddr_t      watch_addr [2][2];
	sdram_pkg::word_t       watch_q [2][2];
	logic                   tog_req [2];
	sdram_pkg::raddr_t      tog_addr [2];
	logic                   tog_ack [2];
	sdram_pkg::word_t       tog_q [2];
	sdram_pkg::sdram_pins_t pins;
	sdram_pkg::word_t       dq_out, dq_in;
	logic                   dq_oe, ready, proto_err;
	int                     ref_count, init_step;

	sdram_pkg::word_t ref_mem [logic [23:0]];   // key {slot, waddr}
	sdram_pkg::word_t exp_q [2];
	int seed = 32'h675e86c7;
	int cyc = 0;
	int last_ref_cnt = 0;
	int last_ref_cyc = 0;
	logic gap_en = 1'b0;
	logic have_ref = 1'b0;

	sdram_ctrl_top uut (
		.clk, .init_n,
		.port_in_0(port_in[0]), .port_ack_0(port_ack[0]), .port_q_0(port_q[0]),
		.watch_addr_0_0(watch_addr[0][0]), .watch_addr_0_1(watch_addr[0][1]),
		.watch_q_0_0(watch_q[0][0]), .watch_q_0_1(watch_q[0][1]),
		.tog_req_0(tog_req[0]), .tog_addr_0(tog_addr[0]),
		.tog_ack_0(tog_ack[0]), .tog_q_0(tog_q[0]),
		.port_in_1(port_in[1]), .port_ack_1(port_ack[1]), .port_q_1(port_q[1]),
		.watch_addr_1_0(watch_addr[1][0]), .watch_addr_1_1(watch_addr[1][1]),
		.watch_q_1_0(watch_q[1][0]), .watch_q_1_1(watch_q[1][1]),
		.tog_req_1(tog_req[1]), .tog_addr_1(tog_addr[1]),
		.tog_ack_1(tog_ack[1]), .tog_q_1(tog_q[1]),
		.pins, .dq_out, .dq_oe, .dq_in, .ready
	);

	sdram_chip_model u_chip (
		.clk, .pins, .dq_out, .dq_oe, .dq_in, .ref_count, .init_step, .proto_err
	);

	always #5 clk = ~clk;   // 10 ns
	always @(posedge clk) cyc <= cyc + 1;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			stop_run("value mismatch");
		end
	endtask

	// refresh gap checked only when both refreshes fall in the window
	always @(negedge clk) begin
		if (ref_count != last_ref_cnt) begin
			if (gap_en && have_ref)
				check(cyc - last_ref_cyc <= GAP_MAX, 1, "refresh gap too long");
			last_ref_cnt = ref_count;
			last_ref_cyc = cyc;
			have_ref     = gap_en;
		end
	end

	task automatic tick;
		@(negedge clk);
	endtask

	// --------------------------------------------------------------
	// reference memory with the chip's fill for unwritten words
	function automatic sdram_pkg::word_t ref_rd(input logic [23:0] k);
		return ref_mem.exists(k) ? ref_mem[k] : (k[15:0] ^ {k[23:16], k[23:16]} ^ 16'h5a3c);
	endfunction

	task automatic ref_wr(input logic [23:0] k, input sdram_pkg::mask_t ds,
			input sdram_pkg::word_t d);
		sdram_pkg::word_t w;
		w = ref_rd(k);
		if (ds[0]) w[7:0] = d[7:0];
		if (ds[1]) w[15:8] = d[15:8];
		ref_mem[k] = w;
	endtask

	// issue on the general port from a negedge
	task automatic start_port(input int s, input logic we, input sdram_pkg::waddr_t a,
			input sdram_pkg::mask_t ds, input sdram_pkg::word_t d);
		port_in[s].we = we;
		port_in[s].a  = a;
		port_in[s].ds = ds;
		port_in[s].d  = d;
		if (we) ref_wr({s[0], a}, ds, d);
		else exp_q[s] = ref_rd({s[0], a});
		port_in[s].req = ~port_in[s].req;
	endtask

	task automatic await_port(input int s);
		int n;
		for (n = 0; port_ack[s] !== port_in[s].req; n++) begin
			if (n == 60) stop_run("timeout waiting for the general port ack");
			tick;
		end
		if (!port_in[s].we) check(port_q[s], exp_q[s], "port read data");
	endtask

	task automatic port_op(input int s, input logic we, input sdram_pkg::waddr_t a,
			input sdram_pkg::mask_t ds, input sdram_pkg::word_t d);
		tick;
		start_port(s, we, a, ds, d);
		await_port(s);
	endtask

	// preload a word then move the watched address onto it
	task automatic watch_read(input int s, input int k, input sdram_pkg::raddr_t ra);
		logic [23:0] key;
		int n;
		key = {s[0], 5'd0, (k == 1) ? 2'b10 : 2'b00, ra};
		port_op(s, 1'b1, key[22:0], 2'b11, 16'($random(seed)));
		tick;
		watch_addr[s][k] = ra;
		for (n = 0; n < 3 * RLEN && watch_q[s][k] !== ref_rd(key); n++)
			tick;
		check(watch_q[s][k], ref_rd(key), "watched reader data");
	endtask

	task automatic tog_op(input int s);
		int n;
		tick;
		tog_req[s] = ~tog_req[s];
		for (n = 0; tog_ack[s] !== tog_req[s]; n++) begin
			if (n == 60) stop_run("timeout waiting for the toggle reader ack");
			tick;
		end
		check(tog_q[s], ref_rd({s[0], 5'd0, 2'b01, tog_addr[s]}), "toggle reader data");
	endtask

	// --------------------------------------------------------------
	// init command order seen before ready rises
	task automatic init_sequence;
		int n;
		for (n = 0; !ready; n++) begin
			if (n == `SDRAM_INIT_ROUNDS * RLEN + 20) stop_run("ready never rose");
			tick;
		end
		check(init_step, 4, "init command order");
	endtask

	// full and partial writes read back on both slots
	task automatic port_write_read;
		int s;
		sdram_pkg::waddr_t a;
		for (s = 0; s < 2; s++) begin
			a = 23'h40_1234 + 23'(s);
			port_op(s, 1'b1, a, 2'b11, 16'($random(seed)));
			port_op(s, 1'b0, a, 2'b11, 16'h0);
			port_op(s, 1'b1, a + 23'd8, 2'b11, 16'ha5c3);
			port_op(s, 1'b1, a + 23'd8, 2'b01, 16'h1234);   // low byte only
			port_op(s, 1'b0, a + 23'd8, 2'b11, 16'h0);
			port_op(s, 1'b1, a + 23'd8, 2'b10, 16'h5678);   // high byte only
			port_op(s, 1'b0, a + 23'd8, 2'b11, 16'h0);
		end
	endtask

	task automatic watched_readers;
		int s;
		for (s = 0; s < 2; s++) begin
			watch_read(s, 0, 16'h0100 + 16'(s));
			watch_read(s, 1, 16'h0200 + 16'(s));
			watch_read(s, 0, 16'hbeef);
		end
	endtask

	// toggle readers read only on a new toggle
	task automatic toggle_readers;
		int s;
		for (s = 0; s < 2; s++) begin
			port_op(s, 1'b1, {5'd0, 2'b01, 16'h0030}, 2'b11, 16'h1111 + 16'(s));
			port_op(s, 1'b1, {5'd0, 2'b01, 16'h0031}, 2'b11, 16'h2222 + 16'(s));
			tick;
			tog_addr[s] = 16'h0030;
			tog_op(s);
			tog_addr[s] = 16'h0031;
			repeat (4 * RLEN) tick;
			check(tog_q[s], 16'h1111 + 16'(s), "toggle reader read without a toggle");
			check(tog_ack[s], tog_req[s], "toggle ack moved");
			tog_op(s);
		end
	endtask

	// refresh spacing while idle and under slot 0 reads
	task automatic refresh_spacing;
		int i, c0;
		gap_en = 1'b1;
		c0 = ref_count;
		repeat (2000) tick;
		check(ref_count - c0 >= 2, 1, "too few refreshes while idle");
		c0 = ref_count;
		for (i = 0; i < 110; i++)
			port_op(0, 1'b0, 23'(i) * 23'h0_0203, 2'b11, 16'h0);
		check(ref_count > c0, 1, "no refresh during slot 0 traffic");
		gap_en = 1'b0;
	endtask

	// random traffic on both slots together
	task automatic random_traffic;
		int i, s;
		sdram_pkg::waddr_t a;
		for (i = 0; i < 200; i++) begin
			tick;
			for (s = 0; s < 2; s++) begin
				a = 23'($random(seed) & 15) * 23'h10_4021;
				if ($random(seed) & 1)
					start_port(s, 1'b1, a, 2'($random(seed)), 16'($random(seed)));
				else
					start_port(s, 1'b0, a, 2'b11, 16'h0);
			end
			await_port(0);
			await_port(1);
		end
	endtask

	// --------------------------------------------------------------
	initial begin
		int s;
		init_n = 1'b0;
		for (s = 0; s < 2; s++) begin
			port_in[s]       = '0;
			watch_addr[s][0] = '0;
			watch_addr[s][1] = '0;
			tog_req[s]       = 1'b0;
			tog_addr[s]      = '0;
		end
		repeat (4) tick;
		init_n = 1'b1;

		init_sequence;
		port_write_read;
		watched_readers;
		toggle_readers;
		refresh_spacing;
		random_traffic;

		check(proto_err, 1'b0, "chip model protocol error");
		$display("Everything OK");
		$finish;
	end

endmodule
